// ==== compile.f ====
+incdir+logic
logic/periph_pkg.sv
logic/periph_gpio.sv
logic/periph_timer.sv
logic/periph_fabric.sv
logic/periph_top.sv
test/periph_checker.sv
test/tb_periph_top.sv

// ==== Makefile ====
# Verilator build and run for the peripheral subsystem

TOP = tb_periph_top

SRCS = compile.f $(wildcard logic/*.sv) $(wildcard logic/*.svh) $(wildcard test/*.sv)

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(SRCS)
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o V$(TOP)

# exit status carries pass or fail
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== test/tb_periph_top.sv ====
//////////////////////////////
// peripheral subsystem testbench
// table driven gpio, decode and timer tests
//////////////////////////////

`include "periph_cfg.svh"

module tb_periph_top
  import periph_pkg::*;
();

  // drive offset after the rising edge
  localparam int DRV        = 2;
  localparam int RSP_LIMIT  = 8;
  localparam int POLL_LIMIT = 10;
  localparam int IRQ_LIMIT  = 200;
  // pins as seen on the data bus
  localparam logic [`PERI_DAT_W-1:0] GPIO_MASK = (32'd1 << `PERI_GPIO_W) - 32'd1;
  localparam logic [`PERI_DAT_W-1:0] OUT_VAL   = 32'hDEAD_BEEF;
  localparam logic [`PERI_DAT_W-1:0] ENA_VAL   = 32'hA5A5_5A5A;
  // timer registers from base 0x10
  localparam logic [`PERI_ADR_W-1:0] TMR_MODE = 8'h10;
  localparam logic [`PERI_ADR_W-1:0] TMR_CNT  = 8'h14;
  localparam logic [`PERI_ADR_W-1:0] TMR_CMP  = 8'h18;
  localparam logic [`PERI_ADR_W-1:0] TMR_STS  = 8'h1C;
  localparam logic [`PERI_DAT_W-1:0] SHOT_C   = 32'd10;
  localparam logic [`PERI_DAT_W-1:0] RUN_C    = 32'd3;

  // one table row
  typedef struct packed {
    tcb_op_e                 op;
    logic [`PERI_ADR_W-1:0]  adr;
    logic [`PERI_DAT_W-1:0]  wdt;
    logic [`PERI_GPIO_W-1:0] pins;
    logic                    poll;
    logic [`PERI_DAT_W-1:0]  rdt;
    tcb_sts_e                sts;
  } step_t;

  logic                    tcb;
  logic                    rst_n;
  logic                    req_vld;
  tcb_req_t                req;
  logic                    req_rdy;
  logic                    rsp_vld;
  tcb_rsp_t                rsp;
  logic [`PERI_GPIO_W-1:0] gpio_i;
  logic [`PERI_GPIO_W-1:0] gpio_o;
  logic [`PERI_GPIO_W-1:0] gpio_e;
  logic                    irq;
  int                      seed;
  step_t                   steps[$];
  string                   step_names[$];

  periph_top u_dut (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .req_vld (req_vld),
    .req     (req),
    .req_rdy (req_rdy),
    .rsp_vld (rsp_vld),
    .rsp     (rsp),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o),
    .gpio_e  (gpio_e),
    .irq     (irq)
  );

  // 40 unit period
  always #20 tcb = ~tcb;

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("Something failed");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [31:0] zext_pins(input logic [`PERI_GPIO_W-1:0] pins);
    logic [31:0] word;
    word = '0;
    word[`PERI_GPIO_W-1:0] = pins;
    return word;
  endfunction

  // one transfer and its response
  task automatic bus_xfer(input tcb_op_e op, input logic [7:0] adr,
                          input logic [31:0] wdt, output tcb_rsp_t got);
    int waited;
    waited = 0;
    @(posedge tcb);
    #DRV;
    req_vld = 1'b1;
    req.op  = op;
    req.adr = adr;
    req.wdt = wdt;
    // hold the request until the fabric is ready
    while (req_rdy !== 1'b1 && waited < RSP_LIMIT) begin
      @(posedge tcb);
      #DRV;
      waited++;
    end
    if (req_rdy !== 1'b1) stop_run("req_rdy stayed low while a transfer was offered");
    // accepting edge
    @(posedge tcb);
    #DRV;
    req_vld = 1'b0;
    waited = 0;
    while (!rsp_vld && waited < RSP_LIMIT) begin
      @(posedge tcb);
      #DRV;
      waited++;
    end
    if (!rsp_vld) stop_run("no response arrived for a bus transfer");
    got = rsp;
  endtask

  task automatic wait_irq(input logic level, input string what);
    int waited;
    waited = 0;
    while (irq !== level && waited < IRQ_LIMIT) begin
      @(posedge tcb);
      #DRV;
      waited++;
    end
    if (irq !== level) stop_run({"irq did not reach the expected level during ", what});
  endtask

  //////////////////////////////
  // stimulus table
  //////////////////////////////

  task automatic add_step(input string name, input tcb_op_e op, input logic [7:0] adr,
                          input logic [31:0] wdt, input logic [15:0] pins,
                          input logic poll, input logic [31:0] rdt, input tcb_sts_e sts);
    step_t s;
    s.op   = op;
    s.adr  = adr;
    s.wdt  = wdt;
    s.pins = pins;
    s.poll = poll;
    s.rdt  = rdt;
    s.sts  = sts;
    steps.push_back(s);
    step_names.push_back(name);
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    // registers keep only the pin bits
    add_step("gpio out write", OP_WRITE, 8'h00, OUT_VAL, '0, 1'b0, '0, STS_OK);
    add_step("gpio out read", OP_READ, 8'h00, '0, '0, 1'b0, OUT_VAL & GPIO_MASK, STS_OK);
    add_step("gpio ena write", OP_WRITE, 8'h04, ENA_VAL, '0, 1'b0, '0, STS_OK);
    add_step("gpio ena read", OP_READ, 8'h04, '0, '0, 1'b0, ENA_VAL & GPIO_MASK, STS_OK);
    add_step("gpio spare read", OP_READ, 8'h0C, '0, '0, 1'b0, '0, STS_OK);
    // random pin patterns through the synchronizer
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      add_step($sformatf("gpio input %0d", i), OP_READ, 8'h08, '0,
               rnd[`PERI_GPIO_W-1:0], 1'b1, zext_pins(rnd[`PERI_GPIO_W-1:0]), STS_OK);
    end
    // unmapped slots 2 and 3
    add_step("decerr write 0x20", OP_WRITE, 8'h20, 32'hFFFF_FFFF, '0, 1'b0, '0, STS_DECERR);
    add_step("decerr read 0x30", OP_READ, 8'h30, '0, '0, 1'b0, '0, STS_DECERR);
    add_step("decerr write 0x30", OP_WRITE, 8'h30, '0, '0, 1'b0, '0, STS_DECERR);
    add_step("decerr read 0x20", OP_READ, 8'h20, '0, '0, 1'b0, '0, STS_DECERR);
    add_step("gpio out kept", OP_READ, 8'h00, '0, '0, 1'b0, OUT_VAL & GPIO_MASK, STS_OK);
    add_step("gpio ena kept", OP_READ, 8'h04, '0, '0, 1'b0, ENA_VAL & GPIO_MASK, STS_OK);
  endtask

  task automatic apply_table();
    step_t    s;
    tcb_rsp_t got;
    int       polls;
    foreach (steps[i]) begin
      s = steps[i];
      if (s.poll) begin
        @(posedge tcb);
        #DRV;
        gpio_i = s.pins;
      end
      bus_xfer(s.op, s.adr, s.wdt, got);
      // input path needs a few edges to settle
      polls = 0;
      while (s.poll && got.rdt !== s.rdt && polls < POLL_LIMIT) begin
        bus_xfer(s.op, s.adr, s.wdt, got);
        polls++;
      end
      if (s.poll && got.rdt !== s.rdt) stop_run("gpio input never showed up in the register");
      check_value({step_names[i], " rdt"}, s.rdt, got.rdt);
      check_value({step_names[i], " sts"}, {31'b0, s.sts}, {31'b0, got.sts});
    end
  endtask

  //////////////////////////////
  // timer sequence
  //////////////////////////////

  task automatic timer_sequence();
    tcb_rsp_t got;
    // oneshot up to SHOT_C
    bus_xfer(OP_WRITE, TMR_CMP, SHOT_C, got);
    bus_xfer(OP_WRITE, TMR_MODE, {30'b0, TMR_ONESHOT}, got);
    wait_irq(1'b1, "oneshot");
    bus_xfer(OP_READ, TMR_CNT, '0, got);
    check_value("oneshot count first", SHOT_C, got.rdt);
    bus_xfer(OP_READ, TMR_CNT, '0, got);
    check_value("oneshot count second", SHOT_C, got.rdt);
    bus_xfer(OP_READ, TMR_MODE, '0, got);
    check_value("oneshot mode", {30'b0, TMR_STOP}, got.rdt);
    bus_xfer(OP_READ, TMR_STS, '0, got);
    check_value("oneshot flag", 32'd1, got.rdt);
    // write one to clear
    bus_xfer(OP_WRITE, TMR_STS, 32'd1, got);
    bus_xfer(OP_READ, TMR_STS, '0, got);
    check_value("flag cleared", 32'd0, got.rdt);
    wait_irq(1'b0, "flag clear");
    // free run with wrap
    bus_xfer(OP_WRITE, TMR_CNT, '0, got);
    bus_xfer(OP_WRITE, TMR_CMP, RUN_C, got);
    bus_xfer(OP_WRITE, TMR_MODE, {30'b0, TMR_RUN}, got);
    wait_irq(1'b1, "run wrap");
    repeat (8) begin
      bus_xfer(OP_READ, TMR_CNT, '0, got);
      check_value("run count bound", 32'd1, {31'b0, got.rdt <= RUN_C});
    end
    bus_xfer(OP_WRITE, TMR_MODE, {30'b0, TMR_STOP}, got);
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    tcb     = 1'b0;
    rst_n   = 1'b0;
    req_vld = 1'b0;
    req     = '0;
    gpio_i  = '0;
    seed    = 38622;
    build_table();
    repeat (4) @(posedge tcb);
    #DRV;
    rst_n = 1'b1;
    check_value("gpio_o after reset", '0, zext_pins(gpio_o));
    check_value("gpio_e after reset", '0, zext_pins(gpio_e));
    check_value("irq after reset", '0, {31'b0, irq});
    check_value("req_rdy after reset", 32'd1, {31'b0, req_rdy});
    apply_table();
    // pins follow the registers
    check_value("gpio_o port", OUT_VAL & GPIO_MASK, zext_pins(gpio_o));
    check_value("gpio_e port", ENA_VAL & GPIO_MASK, zext_pins(gpio_e));
    timer_sequence();
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== test/periph_checker.sv ====
//////////////////////////////
// fabric bus protocol checker
// bound into the fabric
//////////////////////////////

module periph_checker (
  input logic tcb,
  input logic rst_n,
  input logic req_vld,
  input logic req_rdy,
  input logic rsp_vld,
  input logic gpio_vld,
  input logic tmr_vld
);

  // accepted transfer
  logic trn;

  assign trn = req_vld && req_rdy;

  //////////////////////////////
  // response timing
  //////////////////////////////

  // one response per accept, one cycle later
  a_rsp_follows: assert property (@(posedge tcb) disable iff (!rst_n) trn |=> rsp_vld)
    else $error("no response one cycle after an accepted transfer");

  // no response without an accept before it
  a_rsp_cause: assert property (@(posedge tcb) disable iff (!rst_n) rsp_vld |-> $past(trn))
    else $error("response without a preceding accepted transfer");

  //////////////////////////////
  // handshake and decode
  //////////////////////////////

  a_rdy_high: assert property (@(posedge tcb) disable iff (!rst_n) req_rdy)
    else $error("req_rdy low outside reset");

  // decoder selects one target at most
  a_one_sel: assert property (@(posedge tcb) disable iff (!rst_n) !(gpio_vld && tmr_vld))
    else $error("gpio and timer selected together");

endmodule

bind periph_fabric periph_checker u_checker (
  .tcb      (tcb),
  .rst_n    (rst_n),
  .req_vld  (req_vld),
  .req_rdy  (req_rdy),
  .rsp_vld  (rsp_vld),
  .gpio_vld (gpio_vld),
  .tmr_vld  (tmr_vld)
);

// ==== logic/periph_top.sv ====
//////////////////////////////
// peripheral subsystem top
// fabric with gpio and timer
//////////////////////////////

`include "periph_cfg.svh"

module periph_top
  import periph_pkg::*;
(
  input  logic                    tcb,
  input  logic                    rst_n,
  // requester port
  input  logic                    req_vld,
  input  tcb_req_t                req,
  output logic                    req_rdy,
  output logic                    rsp_vld,
  output tcb_rsp_t                rsp,
  // gpio pins
  input  logic [`PERI_GPIO_W-1:0] gpio_i,
  output logic [`PERI_GPIO_W-1:0] gpio_o,
  output logic [`PERI_GPIO_W-1:0] gpio_e,
  // timer interrupt
  output logic                    irq
);

  // per peripheral request valids
  logic     gpio_vld;
  logic     tmr_vld;
  // per peripheral responses
  logic     gpio_rsp_vld;
  tcb_rsp_t gpio_rsp;
  logic     tmr_rsp_vld;
  tcb_rsp_t tmr_rsp;

  periph_fabric u_fabric (
    .tcb          (tcb),
    .rst_n        (rst_n),
    .req_vld      (req_vld),
    .req          (req),
    .req_rdy      (req_rdy),
    .rsp_vld      (rsp_vld),
    .rsp          (rsp),
    .gpio_vld     (gpio_vld),
    .gpio_rsp_vld (gpio_rsp_vld),
    .gpio_rsp     (gpio_rsp),
    .tmr_vld      (tmr_vld),
    .tmr_rsp_vld  (tmr_rsp_vld),
    .tmr_rsp      (tmr_rsp)
  );

  periph_gpio #(
    .GW  (`PERI_GPIO_W),
    .CDC (`PERI_CDC)
  ) u_gpio (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .vld     (gpio_vld),
    .req     (req),
    .rsp_vld (gpio_rsp_vld),
    .rsp     (gpio_rsp),
    .gpio_i  (gpio_i),
    .gpio_o  (gpio_o),
    .gpio_e  (gpio_e)
  );

  periph_timer u_timer (
    .tcb     (tcb),
    .rst_n   (rst_n),
    .vld     (tmr_vld),
    .req     (req),
    .rsp_vld (tmr_rsp_vld),
    .rsp     (tmr_rsp),
    .irq     (irq)
  );

endmodule

// ==== logic/periph_fabric.sv ====
//////////////////////////////
// bus fabric
// address decode and response merge
//////////////////////////////

`include "periph_cfg.svh"

module periph_fabric
  import periph_pkg::*;
(
  input  logic     tcb,
  input  logic     rst_n,
  // requester side
  input  logic     req_vld,
  input  tcb_req_t req,
  output logic     req_rdy,
  output logic     rsp_vld,
  output tcb_rsp_t rsp,
  // gpio side
  output logic     gpio_vld,
  input  logic     gpio_rsp_vld,
  input  tcb_rsp_t gpio_rsp,
  // timer side
  output logic     tmr_vld,
  input  logic     tmr_rsp_vld,
  input  tcb_rsp_t tmr_rsp
);

  // peripheral select field
  logic [1:0] sel;
  // accepted transfer
  logic       trn;
  // unmapped transfer this cycle
  logic       err;
  // registered decode error slot
  logic       err_vld;
  tcb_rsp_t   err_rsp;

  //////////////////////////////
  // request decode
  //////////////////////////////

  // peripherals never stall
  assign req_rdy = 1'b1;
  assign trn     = req_vld && req_rdy;
  assign sel     = req.adr[5:4];

  assign gpio_vld = trn && (sel == `PERI_SEL_GPIO);
  assign tmr_vld  = trn && (sel == `PERI_SEL_TMR);
  assign err      = trn && !gpio_vld && !tmr_vld;

  //////////////////////////////
  // decode error response
  //////////////////////////////

  // same one cycle slot as peripherals
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      err_vld <= 1'b0;
    end else begin
      err_vld <= err;
    end
  end

  // fixed payload
  assign err_rsp.rdt = '0;
  assign err_rsp.sts = STS_DECERR;

  //////////////////////////////
  // response merge
  //////////////////////////////

  // at most one source valid per cycle
  assign rsp_vld = gpio_rsp_vld || tmr_rsp_vld || err_vld;

  always_comb begin
    if (gpio_rsp_vld) begin
      rsp = gpio_rsp;
    end else if (tmr_rsp_vld) begin
      rsp = tmr_rsp;
    end else if (err_vld) begin
      rsp = err_rsp;
    end else begin
      // idle bus
      rsp = '0;
    end
  end

endmodule

// ==== logic/periph_timer.sv ====
//////////////////////////////
// compare timer
// free run or oneshot, sticky match irq
//////////////////////////////

`include "periph_cfg.svh"

module periph_timer
  import periph_pkg::*;
(
  input  logic     tcb,
  input  logic     rst_n,
  // bus side
  input  logic     vld,
  input  tcb_req_t req,
  output logic     rsp_vld,
  output tcb_rsp_t rsp,
  // interrupt
  output logic     irq
);

  // register offsets as word index
  localparam logic [1:0] REG_MODE = 2'd0;
  localparam logic [1:0] REG_CNT  = 2'd1;
  localparam logic [1:0] REG_CMP  = 2'd2;
  localparam logic [1:0] REG_STS  = 2'd3;

  tmr_mode_e              mode;
  logic [`PERI_TMR_W-1:0] cnt;
  logic [`PERI_TMR_W-1:0] cmp;
  // sticky match flag
  logic                   flag;
  logic                   run;
  logic                   hit;
  logic                   wr;
  logic [`PERI_DAT_W-1:0] rd_dat;

  //////////////////////////////
  // counter control
  //////////////////////////////

  assign run = (mode != TMR_STOP);
  // match only counts while running
  assign hit = run && (cnt == cmp);
  assign wr  = vld && (req.op == OP_WRITE);

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      mode <= TMR_STOP;
      cnt  <= '0;
      cmp  <= '0;
      flag <= 1'b0;
    end else begin
      // counting
      if (hit) begin
        if (mode == TMR_RUN) begin
          cnt <= '0;
        end else begin
          // oneshot ends, count holds at compare
          mode <= TMR_STOP;
        end
      end else if (run) begin
        cnt <= cnt + 1'b1;
      end
      // clear by write of 1, a new match wins
      if (wr && (req.adr[3:2] == REG_STS) && req.wdt[0]) begin
        flag <= 1'b0;
      end
      if (hit) begin
        flag <= 1'b1;
      end
      // bus writes override the counter logic
      if (wr) begin
        case (req.adr[3:2])
          REG_MODE: begin
            case (req.wdt[1:0])
              TMR_RUN:     mode <= TMR_RUN;
              TMR_ONESHOT: mode <= TMR_ONESHOT;
              // stop and the unused code
              default:     mode <= TMR_STOP;
            endcase
          end
          REG_CNT: cnt <= req.wdt[`PERI_TMR_W-1:0];
          REG_CMP: cmp <= req.wdt[`PERI_TMR_W-1:0];
          // status handled above
          default: ;
        endcase
      end
    end
  end

  // irq follows flag one cycle later
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      irq <= 1'b0;
    end else begin
      irq <= flag;
    end
  end

  //////////////////////////////
  // read path
  //////////////////////////////

  always_comb begin
    rd_dat = '0;
    case (req.adr[3:2])
      REG_MODE: rd_dat[1:0] = mode;
      REG_CNT:  rd_dat[`PERI_TMR_W-1:0] = cnt;
      REG_CMP:  rd_dat[`PERI_TMR_W-1:0] = cmp;
      REG_STS:  rd_dat[0] = flag;
      default:  rd_dat = '0;
    endcase
  end

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= vld;
    end
  end

  // values seen before the accepting edge
  always_ff @(posedge tcb) begin
    if (vld) begin
      rsp.rdt <= (req.op == OP_READ) ? rd_dat : '0;
      rsp.sts <= STS_OK;
    end
  end

endmodule

// ==== logic/periph_gpio.sv ====
//////////////////////////////
// gpio controller
// output/enable regs, synchronized inputs
//////////////////////////////

`include "periph_cfg.svh"

module periph_gpio
  import periph_pkg::*;
#(
  // number of gpio pins
  parameter int unsigned GW  = `PERI_GPIO_W,
  // synchronizer depth, 0 bypasses
  parameter int unsigned CDC = `PERI_CDC
) (
  input  logic           tcb,
  input  logic           rst_n,
  // bus side
  input  logic           vld,
  input  tcb_req_t       req,
  output logic           rsp_vld,
  output tcb_rsp_t       rsp,
  // pins
  input  logic [GW-1:0]  gpio_i,
  output logic [GW-1:0]  gpio_o,
  output logic [GW-1:0]  gpio_e
);

  // register offsets, word index from adr[3:2]
  localparam logic [1:0] REG_OUT = 2'd0;
  localparam logic [1:0] REG_ENA = 2'd1;
  localparam logic [1:0] REG_INP = 2'd2;

  // synchronized input value
  logic [GW-1:0]          gpio_r;
  // read mux output
  logic [`PERI_DAT_W-1:0] rd_dat;
  logic                   wr;

  //////////////////////////////
  // input synchronizer
  //////////////////////////////

  if (CDC > 0) begin : gen_cdc
    // shift chain, last stage feeds register
    logic [CDC-1:0][GW-1:0] sync;

    always_ff @(posedge tcb or negedge rst_n) begin
      if (!rst_n) begin
        sync <= '0;
      end else begin
        sync[0] <= gpio_i;
        for (int i = 1; i < CDC; i++) begin
          sync[i] <= sync[i-1];
        end
      end
    end

    assign gpio_r = sync[CDC-1];
  end else begin : gen_bypass
    // pins already synchronous
    assign gpio_r = gpio_i;
  end

  //////////////////////////////
  // register writes
  //////////////////////////////

  assign wr = vld && (req.op == OP_WRITE);

  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      gpio_o <= '0;
      gpio_e <= '0;
    end else if (wr) begin
      case (req.adr[3:2])
        REG_OUT: gpio_o <= req.wdt[GW-1:0];
        REG_ENA: gpio_e <= req.wdt[GW-1:0];
        // input reg read only, 0xC ignored
        default: ;
      endcase
    end
  end

  //////////////////////////////
  // read path
  //////////////////////////////

  // zero extended to bus width
  always_comb begin
    rd_dat = '0;
    case (req.adr[3:2])
      REG_OUT: rd_dat[GW-1:0] = gpio_o;
      REG_ENA: rd_dat[GW-1:0] = gpio_e;
      REG_INP: rd_dat[GW-1:0] = gpio_r;
      default: rd_dat = '0;
    endcase
  end

  // one cycle response slot
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      rsp_vld <= 1'b0;
    end else begin
      rsp_vld <= vld;
    end
  end

  // payload sampled with old register values
  always_ff @(posedge tcb) begin
    if (vld) begin
      rsp.rdt <= (req.op == OP_READ) ? rd_dat : '0;
      rsp.sts <= STS_OK;
    end
  end

endmodule

// ==== logic/periph_pkg.sv ====
//////////////////////////////
// peripheral bus types
// request/response structs and enums
//////////////////////////////

`include "periph_cfg.svh"

package periph_pkg;

  //////////////////////////////
  // bus encodings
  //////////////////////////////

  // request opcode
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } tcb_op_e;

  // response status
  typedef enum logic {
    STS_OK     = 1'b0,
    STS_DECERR = 1'b1
  } tcb_sts_e;

  // request payload
  typedef struct packed {
    tcb_op_e                op;
    logic [`PERI_ADR_W-1:0] adr;
    logic [`PERI_DAT_W-1:0] wdt;
  } tcb_req_t;

  // response payload
  typedef struct packed {
    logic [`PERI_DAT_W-1:0] rdt;
    tcb_sts_e               sts;
  } tcb_rsp_t;

  //////////////////////////////
  // timer modes
  //////////////////////////////

  typedef enum logic [1:0] {
    TMR_STOP    = 2'd0,
    TMR_RUN     = 2'd1,
    TMR_ONESHOT = 2'd2
  } tmr_mode_e;

endpackage

// ==== logic/periph_cfg.svh ====
//////////////////////////////
// peripheral subsystem config
// bus widths, gpio sizing, address map
//////////////////////////////

`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// bus widths
`define PERI_ADR_W 8
`define PERI_DAT_W 32

// gpio width, keep at or below data width
`define PERI_GPIO_W 16
// input synchronizer stages, 0 is bypass
`define PERI_CDC 2

// timer counter width
`define PERI_TMR_W 16

// address bits 5:4 select, 2 and 3 unmapped
`define PERI_SEL_GPIO 2'd0
`define PERI_SEL_TMR 2'd1

`endif
